// ==== control.f ====
+incdir+tb
hdl/control_pkg.sv
hdl/command_decoder.sv
hdl/reply_fifo.sv
hdl/reply_sender.sv
hdl/control_top.sv
tb/control_tb.sv

// ==== hdl/command_decoder.sv ====
module command_decoder (
        input  logic                                  clock,
        input  logic                                  reset,
        input  control_pkg::cmd_word_u                rx_word,
        input  logic                                  rx_word_valid,
        input  logic [control_pkg::TIME_WIDTH-1:0]    sim_time,
        input  logic                                  sim_time_tick,
        input  logic                                  sim_error_in,
        input  logic                                  sim_quiescent,
        input  logic [control_pkg::WORD_WIDTH-1:0]    stats_word,
        input  logic                                  full,
        output logic                                  push,
        output logic [control_pkg::WORD_WIDTH-1:0]    push_word,
        output logic                                  sim_reset,
        output control_pkg::sim_ctrl_t                ctrl,
        output logic [control_pkg::WORD_WIDTH-1:0]    config_word,
        output logic                                  config_valid,
        output logic                                  stats_shift,
        output logic                                  control_error,
        output logic                                  sim_error
);

        typedef enum logic [2:0] {
                S_IDLE,
                S_CFG_COUNT,
                S_CFG_DATA,
                S_STATS_COUNT,
                S_STATS_PUSH,
                S_STATUS_FIRST,
                S_STATUS_SECOND
        } state_e;

        state_e                                state;
        logic [control_pkg::WORD_WIDTH-1:0]    remaining;
        logic [control_pkg::TIME_WIDTH-1:0]    timer;
        logic [control_pkg::WORD_WIDTH-1:0]    status_flags;
        logic                                  readout;

        ////////////////////////////////////////
        // Reply words
        ////////////////////////////////////////

        assign readout = (state == S_STATS_PUSH) || (state == S_STATUS_FIRST) ||
                         (state == S_STATUS_SECOND);

        // Stall in place while the FIFO is full
        assign push = readout && !full;

        // Chain advances in the cycle its word is sampled
        assign stats_shift = (state == S_STATS_PUSH) && !full;

        always_comb begin
                status_flags = '0;
                status_flags[3:0] = ctrl;
                status_flags[control_pkg::STATUS_SIM_ERROR_BIT] = sim_error;
                status_flags[control_pkg::STATUS_QUIESCENT_BIT] = sim_quiescent;
        end

        always_comb begin
                case (state)
                S_STATS_PUSH:   push_word = stats_word;
                S_STATUS_FIRST: push_word = {{(control_pkg::WORD_WIDTH -
                                              control_pkg::TIME_WIDTH){1'b0}}, sim_time};
                default:        push_word = status_flags;
                endcase
        end

        ////////////////////////////////////////
        // Command FSM
        ////////////////////////////////////////

        always_ff @(posedge clock) begin
                if (reset) begin
                        state         <= S_IDLE;
                        remaining     <= '0;
                        timer         <= '0;
                        ctrl          <= '0;
                        sim_reset     <= 1'b0;
                        config_valid  <= 1'b0;
                        control_error <= 1'b0;
                        sim_error     <= 1'b0;
                end else begin
                        sim_reset    <= 1'b0;
                        config_valid <= 1'b0;
                        sim_error    <= sim_error | sim_error_in;

                        // Tick timer, stops injection on expiry
                        if (ctrl.timer_enable && sim_time_tick) begin
                                if (timer <= 1) begin
                                        timer               <= '0;
                                        ctrl.stop_injection <= 1'b1;
                                        ctrl.timer_enable   <= 1'b0;
                                end else begin
                                        timer <= timer - 1'b1;
                                end
                        end

                        // No rx handshake, so a word mid readout is lost
                        if (readout && rx_word_valid)
                                control_error <= 1'b1;

                        case (state)
                        S_IDLE: begin
                                if (rx_word_valid) begin
                                        case (rx_word.hdr.opcode)
                                        control_pkg::OP_RESET: begin
                                                sim_reset     <= 1'b1;
                                                ctrl          <= '0;
                                                timer         <= '0;
                                                control_error <= 1'b0;
                                                sim_error     <= 1'b0;
                                        end
                                        control_pkg::OP_CONTROL:
                                                ctrl <= control_pkg::sim_ctrl_t'(rx_word.hdr.arg[3:0]);
                                        control_pkg::OP_TIMER:
                                                timer <= rx_word.hdr.arg[control_pkg::TIME_WIDTH-1:0];
                                        control_pkg::OP_CONFIG: state <= S_CFG_COUNT;
                                        control_pkg::OP_STATS:  state <= S_STATS_COUNT;
                                        control_pkg::OP_STATUS: state <= S_STATUS_FIRST;
                                        default:                control_error <= 1'b1;
                                        endcase
                                end
                        end
                        S_CFG_COUNT, S_STATS_COUNT: begin
                                if (rx_word_valid) begin
                                        remaining <= rx_word.raw;
                                        if (rx_word.raw == '0)
                                                state <= S_IDLE;
                                        else if (state == S_CFG_COUNT)
                                                state <= S_CFG_DATA;
                                        else
                                                state <= S_STATS_PUSH;
                                end
                        end
                        S_CFG_DATA: begin
                                if (rx_word_valid) begin
                                        config_valid <= 1'b1;
                                        remaining    <= remaining - 1'b1;
                                        if (remaining == 1)
                                                state <= S_IDLE;
                                end
                        end
                        S_STATS_PUSH: begin
                                if (!full) begin
                                        remaining <= remaining - 1'b1;
                                        if (remaining == 1)
                                                state <= S_IDLE;
                                end
                        end
                        S_STATUS_FIRST: begin
                                if (!full)
                                        state <= S_STATUS_SECOND;
                        end
                        default: begin
                                if (!full)
                                        state <= S_IDLE;
                        end
                        endcase
                end
        end

        // Payload register
        always_ff @(posedge clock) begin
                if (state == S_CFG_DATA && rx_word_valid)
                        config_word <= rx_word.raw;
        end

        ////////////////////////////////////////
        // Checks
        ////////////////////////////////////////

        // Chain shifts only with a counted push
        assert property (@(posedge clock) disable iff (reset)
                stats_shift |-> push && remaining != '0);

        // FIFO full flag must hold the readout
        assert property (@(posedge clock) disable iff (reset)
                readout && full |=> $stable(state) && $stable(remaining));

        assert property (@(posedge clock) disable iff (reset)
                config_valid |-> $past(rx_word_valid));

endmodule

// ==== hdl/control_pkg.sv ====
package control_pkg;

        ////////////////////////////////////////
        // Word widths
        ////////////////////////////////////////

        localparam int WORD_WIDTH = 16;
        localparam int TIME_WIDTH = 10;

        ////////////////////////////////////////
        // Command encoding
        ////////////////////////////////////////

        // Values 6 to 15 are illegal
        typedef enum logic [3:0] {
                OP_RESET   = 4'd0,
                OP_CONTROL = 4'd1,
                OP_TIMER   = 4'd2,
                OP_CONFIG  = 4'd3,
                OP_STATS   = 4'd4,
                OP_STATUS  = 4'd5
        } opcode_e;

        typedef struct packed {
                opcode_e     opcode;
                logic [11:0] arg;
        } cmd_hdr_t;

        // Header in idle, raw for counts and payload
        typedef union packed {
                cmd_hdr_t              hdr;
                logic [WORD_WIDTH-1:0] raw;
        } cmd_word_u;

        // Same order as OP_CONTROL arg bits 3 to 0
        typedef struct packed {
                logic timer_enable;
                logic stop_injection;
                logic measure;
                logic sim_enable;
        } sim_ctrl_t;

        ////////////////////////////////////////
        // Second status word
        ////////////////////////////////////////

        // Bits 3 to 0 carry sim_ctrl_t, the rest read as zero
        localparam int STATUS_SIM_ERROR_BIT = 4;
        localparam int STATUS_QUIESCENT_BIT = 5;

endpackage

// ==== hdl/control_top.sv ====
module control_top #(
        parameter int REPLY_DEPTH = 8
) (
        input  logic                                  clock,
        input  logic                                  reset,

        // Host link
        input  logic [control_pkg::WORD_WIDTH-1:0]    rx_word,
        input  logic                                  rx_word_valid,
        output logic [control_pkg::WORD_WIDTH-1:0]    tx_word,
        output logic                                  tx_word_valid,
        input  logic                                  tx_ack,

        // Network simulator
        input  logic [control_pkg::TIME_WIDTH-1:0]    sim_time,
        input  logic                                  sim_time_tick,
        input  logic                                  sim_error_in,
        input  logic                                  sim_quiescent,
        input  logic [control_pkg::WORD_WIDTH-1:0]    stats_word,
        output logic                                  sim_reset,
        output logic                                  sim_enable,
        output logic                                  stop_injection,
        output logic                                  measure,
        output logic [control_pkg::WORD_WIDTH-1:0]    config_word,
        output logic                                  config_valid,
        output logic                                  stats_shift,

        // Sticky errors
        output logic                                  control_error,
        output logic                                  sim_error
);

        control_pkg::sim_ctrl_t                ctrl;
        logic                                  push;
        logic [control_pkg::WORD_WIDTH-1:0]    push_word;
        logic                                  pop;
        logic [control_pkg::WORD_WIDTH-1:0]    head_word;
        logic                                  empty;
        logic                                  full;

        // Timer enable stays inside, seen only through status
        assign sim_enable     = ctrl.sim_enable;
        assign measure        = ctrl.measure;
        assign stop_injection = ctrl.stop_injection;

        ////////////////////////////////////////
        // Producer, buffer, consumer
        ////////////////////////////////////////

        command_decoder decoder (
                .clock         (clock),
                .reset         (reset),
                .rx_word       (rx_word),
                .rx_word_valid (rx_word_valid),
                .sim_time      (sim_time),
                .sim_time_tick (sim_time_tick),
                .sim_error_in  (sim_error_in),
                .sim_quiescent (sim_quiescent),
                .stats_word    (stats_word),
                .full          (full),
                .push          (push),
                .push_word     (push_word),
                .sim_reset     (sim_reset),
                .ctrl          (ctrl),
                .config_word   (config_word),
                .config_valid  (config_valid),
                .stats_shift   (stats_shift),
                .control_error (control_error),
                .sim_error     (sim_error)
        );

        reply_fifo #(
                .REPLY_DEPTH (REPLY_DEPTH)
        ) fifo (
                .clock     (clock),
                .reset     (reset),
                .push      (push),
                .push_word (push_word),
                .pop       (pop),
                .head_word (head_word),
                .empty     (empty),
                .full      (full)
        );

        reply_sender sender (
                .clock         (clock),
                .reset         (reset),
                .empty         (empty),
                .head_word     (head_word),
                .pop           (pop),
                .tx_word       (tx_word),
                .tx_word_valid (tx_word_valid),
                .tx_ack        (tx_ack)
        );

endmodule

// ==== hdl/reply_fifo.sv ====
module reply_fifo #(
        parameter int REPLY_DEPTH = 8
) (
        input  logic                                  clock,
        input  logic                                  reset,
        input  logic                                  push,
        input  logic [control_pkg::WORD_WIDTH-1:0]    push_word,
        input  logic                                  pop,
        output logic [control_pkg::WORD_WIDTH-1:0]    head_word,
        output logic                                  empty,
        output logic                                  full
);

        localparam int ADDR_WIDTH = $clog2(REPLY_DEPTH);

        logic [control_pkg::WORD_WIDTH-1:0]    mem [REPLY_DEPTH];
        logic [ADDR_WIDTH-1:0]                 rd_ptr;
        logic [ADDR_WIDTH-1:0]                 wr_ptr;
        logic [ADDR_WIDTH:0]                   count;

        assign head_word = mem[rd_ptr];
        assign empty     = (count == 0);
        assign full      = (count == REPLY_DEPTH);

        ////////////////////////////////////////
        // Storage
        ////////////////////////////////////////

        always_ff @(posedge clock) begin
                if (push)
                        mem[wr_ptr] <= push_word;
        end

        ////////////////////////////////////////
        // Pointers and occupancy
        ////////////////////////////////////////

        // Power of two depth, pointers wrap on their own
        always_ff @(posedge clock) begin
                if (reset) begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push)
                                wr_ptr <= wr_ptr + 1'b1;
                        if (pop)
                                rd_ptr <= rd_ptr + 1'b1;

                        // Push and pop together leave count alone
                        if (push && !pop)
                                count <= count + 1'b1;
                        else if (pop && !push)
                                count <= count - 1'b1;
                end
        end

        ////////////////////////////////////////
        // Checks
        ////////////////////////////////////////

        assert property (@(posedge clock) disable iff (reset) push |-> !full);

        assert property (@(posedge clock) disable iff (reset) pop |-> !empty);

endmodule

// ==== hdl/reply_sender.sv ====
module reply_sender (
        input  logic                                  clock,
        input  logic                                  reset,
        input  logic                                  empty,
        input  logic [control_pkg::WORD_WIDTH-1:0]    head_word,
        output logic                                  pop,
        output logic [control_pkg::WORD_WIDTH-1:0]    tx_word,
        output logic                                  tx_word_valid,
        input  logic                                  tx_ack
);

        // Load only into a free output register
        assign pop = !empty && !tx_word_valid;

        always_ff @(posedge clock) begin
                if (reset) begin
                        tx_word_valid <= 1'b0;
                end else if (pop) begin
                        tx_word_valid <= 1'b1;
                end else if (tx_ack) begin
                        // Ack with valid low falls through harmlessly
                        tx_word_valid <= 1'b0;
                end
        end

        // Held word
        always_ff @(posedge clock) begin
                if (pop)
                        tx_word <= head_word;
        end

        ////////////////////////////////////////
        // Checks
        ////////////////////////////////////////

        // Host sees one steady word until it acks
        assert property (@(posedge clock) disable iff (reset)
                tx_word_valid && !tx_ack |=> tx_word_valid && $stable(tx_word));

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module control_tb -f control.f

# A failing simulation still prints its output for the search below
output=$(./obj_dir/Vcontrol_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
        exit 0
else
        echo "Simulation did not pass"
        exit 1
fi

// ==== tb/control_model.svh ====
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// Reset value of the external statistics chain
localparam logic [63:0] CHAIN_INIT = 64'h1a2b_3c4d_5e6f_7081;

// First status word, sim_time padded with zeros
function automatic logic [15:0] status_time_word(input logic [9:0] t);
        return {6'd0, t};
endfunction

// Quiescent in bit 5, sim error in bit 4, control levels below
function automatic logic [15:0] status_flag_word(input control_pkg::sim_ctrl_t c,
                                                 input logic err, input logic quiet);
        return {10'd0, quiet, err, c};
endfunction

// Chain word seen after n shifts, one 16-bit word per shift
function automatic logic [15:0] stats_value(input logic [63:0] init, input int n);
        logic [63:0] v;
        int          i;
        v = init;
        for (i = 0; i < n % 4; i++)
                v = {v[15:0], v[63:16]};
        return v[15:0];
endfunction

function automatic logic [15:0] config_payload(input int i);
        return {4'ha, i[3:0], 4'h5, ~i[3:0]};
endfunction

// Timer counts down per tick, expiry stops injection
function automatic control_pkg::sim_ctrl_t ctrl_after_ticks(input control_pkg::sim_ctrl_t c,
                                                            input int load, input int ticks);
        control_pkg::sim_ctrl_t r;
        int                     left;
        int                     i;
        r = c;
        left = load;
        for (i = 0; i < ticks; i++) begin
                if (r.timer_enable) begin
                        left = left - 1;
                        if (left <= 0) begin
                                r.stop_injection = 1'b1;
                                r.timer_enable   = 1'b0;
                        end
                end
        end
        return r;
endfunction

// Same layout as output_levels in the testbench
function automatic logic [15:0] expected_levels(input logic rst, input control_pkg::sim_ctrl_t c,
                                                input logic cerr, input logic serr);
        return {7'd0, rst, c.sim_enable, c.measure, c.stop_injection, 3'b000, cerr, serr};
endfunction

`endif

// ==== tb/control_tb.sv ====
module control_tb;

        `include "control_model.svh"

        localparam int TIMEOUT_CYCLES = 4000;

        logic                           clock = 1'b0;
        logic                           reset = 1'b1;
        logic [15:0]                    rx_word = 16'd0;
        logic                           rx_word_valid = 1'b0;
        logic                           tx_ack = 1'b0;
        logic [9:0]                     sim_time = 10'd0;
        logic                           sim_time_tick = 1'b0;
        logic                           sim_error_in = 1'b0;
        logic                           sim_quiescent = 1'b0;
        logic [63:0]                    chain = CHAIN_INIT;
        logic [15:0]                    stats_word;
        logic [15:0]                    tx_word;
        logic                           tx_word_valid;
        logic                           sim_reset;
        logic                           sim_enable;
        logic                           stop_injection;
        logic                           measure;
        logic [15:0]                    config_word;
        logic                           config_valid;
        logic                           stats_shift;
        logic                           control_error;
        logic                           sim_error;

        logic [15:0]                    exp_tx [$];
        logic [15:0]                    exp_cfg [$];
        logic [15:0]                    shift_count = 16'd0;
        logic [15:0]                    shift_base;
        int                             cycle_count = 0;
        int                             ack_delay = 0;
        int                             seed = 51397;
        control_pkg::sim_ctrl_t         model_ctrl;
        logic                           model_sim_error;
        logic                           model_quiet;
        int                             model_shifts;
        int                             i;

        control_top #(.REPLY_DEPTH(8)) uut (
                .clock(clock), .reset(reset),
                .rx_word(rx_word), .rx_word_valid(rx_word_valid),
                .tx_word(tx_word), .tx_word_valid(tx_word_valid), .tx_ack(tx_ack),
                .sim_time(sim_time), .sim_time_tick(sim_time_tick),
                .sim_error_in(sim_error_in), .sim_quiescent(sim_quiescent),
                .stats_word(stats_word), .sim_reset(sim_reset), .sim_enable(sim_enable),
                .stop_injection(stop_injection), .measure(measure),
                .config_word(config_word), .config_valid(config_valid),
                .stats_shift(stats_shift), .control_error(control_error),
                .sim_error(sim_error)
        );

        always #20 clock = ~clock;

        ////////////////////////////////////////
        // Simulator side models
        ////////////////////////////////////////

        assign stats_word = chain[15:0];

        // Chain advances after its word is sampled
        always @(posedge clock) begin
                if (reset)
                        chain <= CHAIN_INIT;
                else if (stats_shift)
                        chain <= {chain[15:0], chain[63:16]};
        end

        // Host acknowledge after 0 to 5 cycles
        always @(posedge clock) begin
                if (reset) begin
                        tx_ack    <= 1'b0;
                        ack_delay <= $unsigned($random(seed)) % 6;
                end else if (tx_ack) begin
                        tx_ack <= 1'b0;
                end else if (tx_word_valid) begin
                        if (ack_delay == 0) begin
                                tx_ack    <= 1'b1;
                                ack_delay <= $unsigned($random(seed)) % 6;
                        end else begin
                                ack_delay <= ack_delay - 1;
                        end
                end
        end

        ////////////////////////////////////////
        // Compare process and timeout
        ////////////////////////////////////////

        always @(posedge clock) begin
                if (!reset) begin
                        if (tx_word_valid && tx_ack) begin
                                if (exp_tx.size() == 0) begin
                                        $display("Reply word %h arrived with none expected",
                                                 tx_word);
                                        $display("RESULT: FAIL");
                                        $fatal(1, "Unexpected reply");
                                end else begin
                                        check_value(tx_word, exp_tx.pop_front(), "tx reply");
                                end
                        end
                        if (config_valid) begin
                                if (exp_cfg.size() == 0) begin
                                        $display("Config word %h arrived with none expected",
                                                 config_word);
                                        $display("RESULT: FAIL");
                                        $fatal(1, "Unexpected config word");
                                end else begin
                                        check_value(config_word, exp_cfg.pop_front(), "config word");
                                end
                        end
                        if (stats_shift)
                                shift_count <= shift_count + 16'd1;
                end
        end

        always @(posedge clock) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("Timeout, the run did not finish within %0d cycles",
                                 TIMEOUT_CYCLES);
                        $display("RESULT: FAIL");
                        $fatal(1, "Timeout");
                end
        end

        ////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////

        task check_value(input logic [15:0] actual, input logic [15:0] expected, input string what);
                if (actual !== expected) begin
                        $display("Error at time %0t: %s mismatch, got %h, expected %h",
                                 $time, what, actual, expected);
                        $display("RESULT: FAIL");
                        $fatal(1, "Mismatch");
                end
        endtask

        function automatic logic [15:0] command(input logic [3:0] op, input logic [11:0] arg);
                return {op, arg};
        endfunction

        function automatic logic [15:0] output_levels();
                return {7'd0, sim_reset, sim_enable, measure, stop_injection, config_valid,
                        stats_shift, tx_word_valid, control_error, sim_error};
        endfunction

        // One rx strobe, then gap idle cycles
        task send_word(input logic [15:0] w, input int gap);
                rx_word       <= w;
                rx_word_valid <= 1'b1;
                @(posedge clock);
                rx_word_valid <= 1'b0;
                repeat (gap) @(posedge clock);
        endtask

        task pulse_tick();
                sim_time_tick <= 1'b1;
                sim_time      <= sim_time + 10'd1;
                @(posedge clock);
                sim_time_tick <= 1'b0;
                @(posedge clock);
        endtask

        task request_status();
                exp_tx.push_back(status_time_word(sim_time));
                exp_tx.push_back(status_flag_word(model_ctrl, model_sim_error, model_quiet));
                send_word(command(control_pkg::OP_STATUS, 12'd0), 0);
        endtask

        task wait_replies();
                while (exp_tx.size() != 0 || exp_cfg.size() != 0)
                        @(posedge clock);
                repeat (2) @(posedge clock);
        endtask

        // Sample mid cycle, resume on the next rising edge
        task check_levels(input logic [15:0] want, input string what);
                @(negedge clock);
                check_value(output_levels(), want, what);
                @(posedge clock);
        endtask

        ////////////////////////////////////////
        // Stimulus
        ////////////////////////////////////////

        initial begin
                model_ctrl      = '0;
                model_sim_error = 1'b0;
                model_quiet     = 1'b0;
                model_shifts    = 0;
                repeat (10) @(posedge clock);
                reset <= 1'b0;

                // Control levels, status, reset pulse
                check_levels(16'd0, "levels after reset");
                send_word(command(control_pkg::OP_CONTROL, 12'd11), 0);
                model_ctrl = 4'b1011;
                check_levels(expected_levels(1'b0, model_ctrl, 1'b0, 1'b0), "control levels");
                request_status();
                wait_replies();
                send_word(command(control_pkg::OP_RESET, 12'd0), 0);
                model_ctrl = '0;
                check_levels(expected_levels(1'b1, model_ctrl, 1'b0, 1'b0), "reset pulse");
                check_levels(expected_levels(1'b0, model_ctrl, 1'b0, 1'b0), "after reset pulse");

                // Config burst, with gaps and back to back
                for (i = 0; i < 5; i++)
                        exp_cfg.push_back(config_payload(i));
                send_word(command(control_pkg::OP_CONFIG, 12'd0), 2);
                send_word(16'd5, 1);
                send_word(config_payload(0), 3);
                send_word(config_payload(1), 0);
                send_word(config_payload(2), 0);
                send_word(config_payload(3), 2);
                send_word(config_payload(4), 0);
                wait_replies();

                // Stats readout deeper than the reply FIFO
                for (i = 0; i < 12; i++)
                        exp_tx.push_back(stats_value(CHAIN_INIT, model_shifts + i));
                model_shifts = model_shifts + 12;
                shift_base = shift_count;
                send_word(command(control_pkg::OP_STATS, 12'd0), 0);
                send_word(16'd12, 0);
                wait_replies();
                check_value(shift_count - shift_base, 16'd12, "stats_shift pulses");

                // Tick timer expiry
                sim_quiescent <= 1'b1;
                model_quiet = 1'b1;
                send_word(command(control_pkg::OP_TIMER, 12'd4), 1);
                send_word(command(control_pkg::OP_CONTROL, 12'd9), 1);
                model_ctrl = 4'b1001;
                repeat (3) pulse_tick();
                check_levels(expected_levels(1'b0, ctrl_after_ticks(model_ctrl, 4, 3), 1'b0, 1'b0),
                             "levels before expiry");
                pulse_tick();
                model_ctrl = ctrl_after_ticks(model_ctrl, 4, 4);
                check_levels(expected_levels(1'b0, model_ctrl, 1'b0, 1'b0), "levels after expiry");
                request_status();
                wait_replies();

                // Sticky errors
                send_word(command(4'd9, 12'd0), 0);
                check_levels(expected_levels(1'b0, model_ctrl, 1'b1, 1'b0), "illegal opcode");
                send_word(command(control_pkg::OP_RESET, 12'd0), 0);
                model_ctrl = '0;
                check_levels(expected_levels(1'b1, model_ctrl, 1'b0, 1'b0), "error clear");
                request_status();
                // Dropped, arrives while the status words are pushed
                send_word(command(control_pkg::OP_CONTROL, 12'd1), 0);
                wait_replies();
                check_levels(expected_levels(1'b0, model_ctrl, 1'b1, 1'b0), "rx during status");
                sim_error_in <= 1'b1;
                @(posedge clock);
                sim_error_in <= 1'b0;
                model_sim_error = 1'b1;
                check_levels(expected_levels(1'b0, model_ctrl, 1'b1, 1'b1), "sim error latch");
                sim_quiescent <= 1'b0;
                model_quiet = 1'b0;
                @(posedge clock);
                request_status();
                wait_replies();
                send_word(command(control_pkg::OP_RESET, 12'd0), 0);
                model_sim_error = 1'b0;
                check_levels(expected_levels(1'b1, model_ctrl, 1'b0, 1'b0), "errors after reset");
                check_levels(16'd0, "idle at end");

                wait_replies();
                $display("RESULT: PASS");
                $finish;
        end

endmodule
